// ==== logic/sa_defines.svh ====
// Array geometry for the systolic matrix unit
// Include this wherever the lane count or lane width is needed
`ifndef SA_DEFINES_SVH
`define SA_DEFINES_SVH

// Array edge, one PE row per input lane
`define SA_DIM 4

// Lane and packed row widths
`define SA_LANE_W 32
`define SA_ROW_W (`SA_DIM * `SA_LANE_W)

// Deepest wavefront delay
`define SA_SKEW (`SA_DIM - 1)

`endif

// ==== logic/sa_ctrl_pkg.sv ====
// Control types for the job FSM of the matrix unit
// Imported by the control block and by the top for the row select wire

`include "sa_defines.svh"

package sa_ctrl_pkg;

  // Job sequence, one pass per ap_start edge
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_STREAM,
    ST_DRAIN,
    ST_DONE
  } sa_state_t;

  // Weight row counter
  typedef logic [$clog2(`SA_DIM)-1:0] sa_beat_t;

endpackage

// ==== logic/sa_data_pkg.sv ====
// Data path types shared by the stream stages and the PE grid
// A row is four lanes, lane 3 in the lowest bits when packed

`include "sa_defines.svh"

package sa_data_pkg;

  // One word of a row
  typedef logic [`SA_LANE_W-1:0] sa_lane_t;

  // Packed row as seen on the streams
  typedef logic [`SA_ROW_W-1:0] sa_row_t;

  // Row split into lanes, index is the lane number
  typedef sa_lane_t sa_lane_vec_t [`SA_DIM];

  // One flag per lane
  typedef logic [`SA_DIM-1:0] sa_flag_vec_t;

endpackage

// ==== logic/sa_stream_if.sv ====
// Skewed wavefront between pipeline stages
// Each lane carries its own valid and last, offset in time from its neighbours

interface sa_stream_if
  import sa_data_pkg::*;
();

  sa_lane_vec_t lane;
  sa_flag_vec_t valid;
  sa_flag_vec_t last;

  // Producing stage
  modport src (
    output lane,
    output valid,
    output last
  );

  // Consuming stage
  modport dst (
    input lane,
    input valid,
    input last
  );

endinterface

// ==== logic/sa_control.sv ====
// Job control for the matrix unit
// Detects the ap_start edge, loads four weight rows, streams rows, then pulses done

`include "sa_defines.svh"

module sa_control
  import sa_ctrl_pkg::*;
(
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     ap_start,
  input  logic     weight_tvalid,
  input  logic     in_tvalid,
  input  logic     in_tlast,
  input  logic     advance,
  input  logic     last_out_fire,
  output logic     ap_idle,
  output logic     ap_done,
  output logic     weight_tready,
  output logic     in_tready,
  output logic     weights_loaded,
  output logic     w_load,
  output sa_beat_t w_row,
  output logic     accept_row
);

  sa_state_t state_q;
  sa_state_t state_d;
  sa_beat_t  beat_q;
  logic      start_q;
  logic      start_pulse;
  logic      last_beat;

  ////////////////////
  // Start edge
  ////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= ap_start;
    end
  end

  assign start_pulse = ap_start & ~start_q;

  ////////////////////
  // Handshakes
  ////////////////////
  assign weight_tready = (state_q == ST_LOAD);
  assign w_load        = weight_tvalid & weight_tready;
  assign w_row         = beat_q;
  assign last_beat     = w_load && (beat_q == sa_beat_t'(`SA_SKEW));

  // Rows only enter while the whole pipeline moves
  assign in_tready  = advance & (state_q == ST_STREAM);
  assign accept_row = in_tvalid & in_tready;

  assign ap_idle = (state_q == ST_IDLE);
  assign ap_done = (state_q == ST_DONE);

  ////////////////////
  // Job FSM
  ////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:   if (start_pulse) state_d = ST_LOAD;
      ST_LOAD:   if (last_beat) state_d = ST_STREAM;
      ST_STREAM: if (accept_row && in_tlast) state_d = ST_DRAIN;
      ST_DRAIN:  if (last_out_fire) state_d = ST_DONE;
      ST_DONE:   state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Beat count restarts for every job
  always_ff @(posedge ap_clk) begin
    if (areset || state_q == ST_IDLE) begin
      beat_q <= '0;
    end else if (w_load) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // High from the fourth weight beat through the done cycle
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      weights_loaded <= 1'b0;
    end else if (last_beat) begin
      weights_loaded <= 1'b1;
    end else if (state_q == ST_DONE) begin
      weights_loaded <= 1'b0;
    end
  end

endmodule

// ==== logic/sa_row_skew.sv ====
// Input stage of the systolic pipeline
// Lane i of an accepted row leaves i advancing cycles after lane 0

`include "sa_defines.svh"

module sa_row_skew
  import sa_data_pkg::*;
(
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     advance,
  input  logic     accept_row,
  input  sa_row_t  in_tdata,
  input  logic     in_tlast,
  sa_stream_if.src wave
);

  sa_lane_vec_t row_lane;

  // Lane 3 sits in the lowest bits
  for (genvar i = 0; i < `SA_DIM; i++) begin : g_unpack
    assign row_lane[i] = in_tdata[(`SA_SKEW - i) * `SA_LANE_W +: `SA_LANE_W];
  end

  for (genvar i = 0; i < `SA_DIM; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign wave.lane[i]  = row_lane[i];
      assign wave.valid[i] = accept_row;
      assign wave.last[i]  = accept_row & in_tlast;
    end else begin : g_delay
      sa_lane_t     lane_q [i];
      logic [i-1:0] vld_q;
      logic [i-1:0] last_q;

      always_ff @(posedge ap_clk) begin
        if (advance) begin
          lane_q[0] <= row_lane[i];
          for (int k = 1; k < i; k++) begin
            lane_q[k] <= lane_q[k-1];
          end
        end
      end

      always_ff @(posedge ap_clk) begin
        if (areset) begin
          vld_q  <= '0;
          last_q <= '0;
        end else if (advance) begin
          vld_q[0]  <= accept_row;
          last_q[0] <= accept_row & in_tlast;
          for (int k = 1; k < i; k++) begin
            vld_q[k]  <= vld_q[k-1];
            last_q[k] <= last_q[k-1];
          end
        end
      end

      assign wave.lane[i]  = lane_q[i-1];
      assign wave.valid[i] = vld_q[i-1];
      assign wave.last[i]  = last_q[i-1];
    end
  end

endmodule

// ==== logic/sa_pe_array.sv ====
// Weight-stationary 4x4 PE grid
// x moves right along each row, partial sums move down each column
// The bottom row delivers one column sum per cycle, column j one cycle after j-1

`include "sa_defines.svh"

module sa_pe_array
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input  logic     ap_clk,
  input  logic     areset,
  input  logic     advance,
  input  logic     w_load,
  input  sa_beat_t w_row,
  input  sa_row_t  weight_tdata,
  sa_stream_if.dst wave_in,
  sa_stream_if.src wave_out
);

  // W[i][j] sits in the cell of row i, column j
  sa_lane_t w_q [`SA_DIM][`SA_DIM];

  // x passed to the right, none leaves the last column
  sa_lane_t x_q [`SA_DIM][`SA_SKEW];

  // Partial sums passed down
  sa_lane_t psum_q [`SA_DIM][`SA_DIM];

  // Flags follow x of the bottom row
  sa_flag_vec_t vld_q;
  sa_flag_vec_t last_q;

  ////////////////////
  // Weight load
  ////////////////////
  always_ff @(posedge ap_clk) begin
    if (w_load) begin
      for (int j = 0; j < `SA_DIM; j++) begin
        w_q[w_row][j] <= weight_tdata[(`SA_SKEW - j) * `SA_LANE_W +: `SA_LANE_W];
      end
    end
  end

  ////////////////////
  // MAC cells
  ////////////////////
  for (genvar i = 0; i < `SA_DIM; i++) begin : g_row
    for (genvar j = 0; j < `SA_DIM; j++) begin : g_col
      sa_lane_t x_in;
      sa_lane_t sum_in;

      // Idle lanes feed zero so empty slots stay quiet
      if (j == 0) begin : g_x_edge
        assign x_in = wave_in.valid[i] ? wave_in.lane[i] : '0;
      end else begin : g_x_pass
        assign x_in = x_q[i][j-1];
      end

      if (i == 0) begin : g_sum_top
        assign sum_in = '0;
      end else begin : g_sum_pass
        assign sum_in = psum_q[i-1][j];
      end

      // Product wraps to the lane width
      always_ff @(posedge ap_clk) begin
        if (advance) begin
          psum_q[i][j] <= sum_in + x_in * w_q[i][j];
        end
      end

      if (j < `SA_SKEW) begin : g_x_reg
        always_ff @(posedge ap_clk) begin
          if (advance) begin
            x_q[i][j] <= x_in;
          end
        end
      end
    end
  end

  ////////////////////
  // Column flags
  ////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      vld_q  <= '0;
      last_q <= '0;
    end else if (advance) begin
      vld_q[0]  <= wave_in.valid[`SA_SKEW];
      last_q[0] <= wave_in.last[`SA_SKEW];
      for (int j = 1; j < `SA_DIM; j++) begin
        vld_q[j]  <= vld_q[j-1];
        last_q[j] <= last_q[j-1];
      end
    end
  end

  for (genvar j = 0; j < `SA_DIM; j++) begin : g_out
    assign wave_out.lane[j] = psum_q[`SA_SKEW][j];
  end

  assign wave_out.valid = vld_q;
  assign wave_out.last  = last_q;

endmodule

// ==== logic/sa_col_deskew.sv ====
// Output stage of the systolic pipeline
// Realigns the column sums into one row and holds it until the sink takes it

`include "sa_defines.svh"

module sa_col_deskew
  import sa_data_pkg::*;
(
  input  logic     ap_clk,
  input  logic     areset,
  sa_stream_if.dst wave,
  input  logic     out_tready,
  output logic     out_tvalid,
  output sa_row_t  out_tdata,
  output logic     out_tlast,
  output logic     advance,
  output logic     last_out_fire
);

  sa_lane_vec_t al_lane;
  sa_flag_vec_t al_valid;
  sa_flag_vec_t al_last;

  // Whole pipeline moves when the output slot is free or being drained
  assign advance = ~out_tvalid | out_tready;

  // Column j waits 3 - j cycles
  for (genvar j = 0; j < `SA_DIM; j++) begin : g_col
    if (j == `SA_SKEW) begin : g_direct
      assign al_lane[j]  = wave.lane[j];
      assign al_valid[j] = wave.valid[j];
      assign al_last[j]  = wave.last[j];
    end else begin : g_delay
      sa_lane_t                lane_q [`SA_SKEW - j];
      logic [`SA_SKEW-j-1:0]   vld_q;
      logic [`SA_SKEW-j-1:0]   last_q;

      always_ff @(posedge ap_clk) begin
        if (advance) begin
          lane_q[0] <= wave.lane[j];
          for (int k = 1; k < `SA_SKEW - j; k++) begin
            lane_q[k] <= lane_q[k-1];
          end
        end
      end

      always_ff @(posedge ap_clk) begin
        if (areset) begin
          vld_q  <= '0;
          last_q <= '0;
        end else if (advance) begin
          vld_q[0]  <= wave.valid[j];
          last_q[0] <= wave.last[j];
          for (int k = 1; k < `SA_SKEW - j; k++) begin
            vld_q[k]  <= vld_q[k-1];
            last_q[k] <= last_q[k-1];
          end
        end
      end

      assign al_lane[j]  = lane_q[`SA_SKEW - j - 1];
      assign al_valid[j] = vld_q[`SA_SKEW - j - 1];
      assign al_last[j]  = last_q[`SA_SKEW - j - 1];
    end
  end

  ////////////////////
  // Output register
  ////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      out_tvalid <= 1'b0;
    end else if (advance) begin
      out_tvalid <= &al_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (advance) begin
      out_tlast <= &al_last;
      for (int j = 0; j < `SA_DIM; j++) begin
        out_tdata[(`SA_SKEW - j) * `SA_LANE_W +: `SA_LANE_W] <= al_lane[j];
      end
    end
  end

  assign last_out_fire = out_tvalid & out_tready & out_tlast;

endmodule

// ==== logic/sa_top.sv ====
// Top of the systolic matrix unit
// Weight, input and output rows on valid/ready streams, kernel-style start and done

module sa_top
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input  logic    ap_clk,
  input  logic    areset,
  input  logic    ap_start,
  output logic    ap_idle,
  output logic    ap_done,
  output logic    weights_loaded,
  input  logic    weight_tvalid,
  output logic    weight_tready,
  input  sa_row_t weight_tdata,
  input  logic    in_tvalid,
  output logic    in_tready,
  input  sa_row_t in_tdata,
  input  logic    in_tlast,
  output logic    out_tvalid,
  input  logic    out_tready,
  output sa_row_t out_tdata,
  output logic    out_tlast
);

  logic     advance;
  logic     accept_row;
  logic     w_load;
  sa_beat_t w_row;
  logic     last_out_fire;

  // Skew to array, array to deskew
  sa_stream_if skew_wave ();
  sa_stream_if sum_wave ();

  sa_control u_control (
    .ap_clk         (ap_clk),
    .areset         (areset),
    .ap_start       (ap_start),
    .weight_tvalid  (weight_tvalid),
    .in_tvalid      (in_tvalid),
    .in_tlast       (in_tlast),
    .advance        (advance),
    .last_out_fire  (last_out_fire),
    .ap_idle        (ap_idle),
    .ap_done        (ap_done),
    .weight_tready  (weight_tready),
    .in_tready      (in_tready),
    .weights_loaded (weights_loaded),
    .w_load         (w_load),
    .w_row          (w_row),
    .accept_row     (accept_row)
  );

  sa_row_skew u_row_skew (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .advance    (advance),
    .accept_row (accept_row),
    .in_tdata   (in_tdata),
    .in_tlast   (in_tlast),
    .wave       (skew_wave.src)
  );

  sa_pe_array u_pe_array (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .advance      (advance),
    .w_load       (w_load),
    .w_row        (w_row),
    .weight_tdata (weight_tdata),
    .wave_in      (skew_wave.dst),
    .wave_out     (sum_wave.src)
  );

  sa_col_deskew u_col_deskew (
    .ap_clk        (ap_clk),
    .areset        (areset),
    .wave          (sum_wave.dst),
    .out_tready    (out_tready),
    .out_tvalid    (out_tvalid),
    .out_tdata     (out_tdata),
    .out_tlast     (out_tlast),
    .advance       (advance),
    .last_out_fire (last_out_fire)
  );

endmodule

// ==== sim/sa_sva.sv ====
// Port protocol checks for the matrix unit
// Bound into sa_top, failures show up as assertion errors

module sa_sva
  import sa_data_pkg::*;
(
  input logic    ap_clk,
  input logic    areset,
  input logic    ap_done,
  input logic    weight_tready,
  input logic    in_tready,
  input logic    out_tvalid,
  input logic    out_tready,
  input logic    out_tlast,
  input sa_row_t out_tdata
);

  // Number of failed properties
  int fail_count = 0;

  // Output slot is empty once reset has been seen
  a_out_empty_after_reset: assert property (@(posedge ap_clk) areset |=> !out_tvalid)
    else begin
      fail_count++;
      $error("out_tvalid high in the cycle after reset");
    end

  a_done_single: assert property (@(posedge ap_clk) disable iff (areset) ap_done |=> !ap_done)
    else begin
      fail_count++;
      $error("ap_done held for more than one cycle");
    end

  // Weight and input phases never overlap
  a_ready_exclusive: assert property (@(posedge ap_clk) disable iff (areset)
    !(weight_tready && in_tready))
    else begin
      fail_count++;
      $error("weight_tready and in_tready high together");
    end

  a_out_hold: assert property (@(posedge ap_clk) disable iff (areset)
    out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) && $stable(out_tlast))
    else begin
      fail_count++;
      $error("Output row changed while stalled");
    end

endmodule

bind sa_top sa_sva u_sva (
  .ap_clk        (ap_clk),
  .areset        (areset),
  .ap_done       (ap_done),
  .weight_tready (weight_tready),
  .in_tready     (in_tready),
  .out_tvalid    (out_tvalid),
  .out_tready    (out_tready),
  .out_tlast     (out_tlast),
  .out_tdata     (out_tdata)
);

// ==== sim/sa_tb.sv ====
// Testbench for the systolic matrix unit
// Runs the jobs from the pattern file and checks every output row against a reference product

`include "sa_defines.svh"

module sa_tb
  import sa_data_pkg::*;
();

  localparam int          JOBS    = 2;
  localparam int          BEATS   = 2 * `SA_DIM;
  localparam int          ROWS    = JOBS * `SA_DIM;
  localparam int          TIMEOUT = 1000;
  localparam int unsigned SEED    = 32'h0231_6084;

  logic    ap_clk = 1'b0;
  logic    areset;
  logic    ap_start;
  logic    ap_idle;
  logic    ap_done;
  logic    weights_loaded;
  logic    weight_tvalid;
  logic    weight_tready;
  sa_row_t weight_tdata;
  logic    in_tvalid;
  logic    in_tready;
  sa_row_t in_tdata;
  logic    in_tlast;
  logic    out_tvalid;
  logic    out_tready = 1'b0;
  sa_row_t out_tdata;
  logic    out_tlast;

  // Tlast nibble sits above the packed row
  logic [`SA_ROW_W+3:0] pat_mem [JOBS * BEATS];
  sa_row_t              exp_rows [ROWS];

  // Written by the initial process only
  int errors = 0;
  int timeouts = 0;

  // Written by the edge monitor only
  int w_fired = 0;
  int in_fired = 0;
  int rows_out = 0;
  int done_pulses = 0;
  int mon_errors = 0;

  sa_top dut (.*);

  always #10 ap_clk = ~ap_clk;

  // Sink takes a row about three cycles in four
  always @(negedge ap_clk) begin
    out_tready <= ($urandom % 4) != 0;
  end

  function automatic sa_lane_t lane_of(sa_row_t row, int idx);
    return row[(`SA_DIM - 1 - idx) * `SA_LANE_W +: `SA_LANE_W];
  endfunction

  // Pattern line of output row n
  function automatic int row_index(int n);
    return (n / `SA_DIM) * BEATS + `SA_DIM + (n % `SA_DIM);
  endfunction

  // y[j] = sum over i of x[i] * W[i][j], wrapped to 32 bits
  function automatic sa_row_t ref_product(int job, sa_row_t x);
    sa_row_t  y;
    sa_lane_t acc;
    y = '0;
    for (int j = 0; j < `SA_DIM; j++) begin
      acc = '0;
      for (int i = 0; i < `SA_DIM; i++) begin
        acc = acc + lane_of(x, i) * lane_of(pat_mem[job * BEATS + i][`SA_ROW_W-1:0], j);
      end
      y[(`SA_DIM - 1 - j) * `SA_LANE_W +: `SA_LANE_W] = acc;
    end
    return y;
  endfunction

  task automatic check_row;
    sa_row_t exp_data;
    logic    exp_last;
    assert (rows_out < ROWS) else begin
      mon_errors++;
      $display("Extra output row at %0t beyond the %0d expected", $time, ROWS);
    end
    if (rows_out < ROWS) begin
      exp_data = exp_rows[rows_out];
      exp_last = pat_mem[row_index(rows_out)][`SA_ROW_W];
      assert (out_tdata == exp_data) else begin
        mon_errors++;
        $display("MISMATCH %0t: row %0d is %h, expected %h", $time, rows_out, out_tdata,
                 exp_data);
      end
      assert (out_tlast == exp_last) else begin
        mon_errors++;
        $display("MISMATCH %0t: row %0d tlast %b, expected %b", $time, rows_out, out_tlast,
                 exp_last);
      end
    end
    rows_out++;
  endtask

  ////////////////////
  // Edge monitor
  ////////////////////
  always @(posedge ap_clk) begin
    if (!areset) begin
      if (weight_tvalid && weight_tready) begin
        w_fired++;
      end
      if (in_tvalid && in_tready) begin
        in_fired++;
      end
      if (out_tvalid && out_tready) begin
        check_row();
      end
      if (ap_done) begin
        assert (rows_out == (done_pulses + 1) * `SA_DIM) else begin
          mon_errors++;
          $display("MISMATCH %0t: ap_done after %0d output rows", $time, rows_out);
        end
        done_pulses++;
      end
    end
  end

  // Holds one beat on a stream until the monitor has seen it taken
  task automatic push_beat(input logic to_weight, input sa_row_t data, input logic last);
    int target;
    int waited;
    target = (to_weight ? w_fired : in_fired) + 1;
    waited = 0;
    if (to_weight) begin
      weight_tvalid = 1'b1;
      weight_tdata  = data;
    end else begin
      in_tvalid = 1'b1;
      in_tdata  = data;
      in_tlast  = last;
    end
    do begin
      @(negedge ap_clk);
      waited++;
    end while ((to_weight ? w_fired : in_fired) < target && waited < TIMEOUT);
    assert ((to_weight ? w_fired : in_fired) == target) else begin
      timeouts++;
      $display("Timeout at %0t, a %s beat was never accepted", $time,
               to_weight ? "weight" : "input");
    end
    weight_tvalid = 1'b0;
    in_tvalid     = 1'b0;
    in_tlast      = 1'b0;
  endtask

  task automatic run_job(input int job);
    int idx;
    int waited;
    ap_start = 1'b1;
    waited = 0;
    do begin
      @(negedge ap_clk);
      waited++;
    end while (ap_idle && waited < TIMEOUT);
    assert (!ap_idle) else begin
      timeouts++;
      $display("Timeout at %0t, ap_idle never fell after the start edge", $time);
    end
    ap_start = 1'b0;

    for (int k = 0; k < `SA_DIM; k++) begin
      push_beat(1'b1, pat_mem[job * BEATS + k][`SA_ROW_W-1:0], 1'b0);
    end
    waited = 0;
    while (!weights_loaded && waited < TIMEOUT) begin
      @(negedge ap_clk);
      waited++;
    end
    assert (weights_loaded) else begin
      timeouts++;
      $display("Timeout at %0t, weights_loaded never rose", $time);
    end
    assert (w_fired == (job + 1) * `SA_DIM && !weight_tready) else begin
      errors++;
      $display("MISMATCH %0t: %0d weight beats taken, weight_tready %b", $time, w_fired,
               weight_tready);
    end

    for (int r = 0; r < `SA_DIM; r++) begin
      idx = job * BEATS + `SA_DIM + r;
      push_beat(1'b0, pat_mem[idx][`SA_ROW_W-1:0], pat_mem[idx][`SA_ROW_W]);
    end

    // Done follows the tlast output row
    waited = 0;
    while (done_pulses <= job && waited < TIMEOUT) begin
      @(negedge ap_clk);
      waited++;
    end
    @(negedge ap_clk);
    assert (done_pulses == job + 1) else begin
      timeouts++;
      $display("Timeout at %0t, ap_done pulsed %0d times for job %0d", $time, done_pulses, job);
    end
    assert (ap_idle && !ap_done && !weights_loaded) else begin
      errors++;
      $display("MISMATCH %0t: after done idle %b done %b loaded %b", $time, ap_idle, ap_done,
               weights_loaded);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    $readmemh("sim/sa_patterns.hex", pat_mem);
    areset        = 1'b1;
    ap_start      = 1'b0;
    weight_tvalid = 1'b0;
    weight_tdata  = '0;
    in_tvalid     = 1'b0;
    in_tdata      = '0;
    in_tlast      = 1'b0;
    for (int n = 0; n < ROWS; n++) begin
      exp_rows[n] = ref_product(n / `SA_DIM, pat_mem[row_index(n)][`SA_ROW_W-1:0]);
    end

    repeat (8) @(negedge ap_clk);
    areset = 1'b0;
    assert (ap_idle && !ap_done && !out_tvalid && !weights_loaded) else begin
      errors++;
      $display("MISMATCH %0t: after reset idle %b done %b out_tvalid %b loaded %b", $time,
               ap_idle, ap_done, out_tvalid, weights_loaded);
    end

    for (int job = 0; job < JOBS; job++) begin
      run_job(job);
    end
    assert (rows_out == ROWS) else begin
      errors++;
      $display("MISMATCH %0t: %0d output rows, expected %0d", $time, rows_out, ROWS);
    end

    $display("Errors: %0d checks, %0d monitor, %0d timeouts, %0d assertions", errors,
             mon_errors, timeouts, dut.u_sva.fail_count);
    if (errors == 0 && mon_errors == 0 && timeouts == 0 && dut.u_sva.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/sa_ctrl_pkg.sv
logic/sa_data_pkg.sv
logic/sa_stream_if.sv
logic/sa_control.sv
logic/sa_row_skew.sv
logic/sa_pe_array.sv
logic/sa_col_deskew.sv
logic/sa_top.sv
sim/sa_sva.sv
sim/sa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the systolic unit testbench with Verilator and runs it, all output goes to sim.log
# A failed build, a crashed run or a reported failure gives a nonzero exit status

verilator --binary --assert --top-module sa_tb -f files.f -o sa_sim > sim.log 2>&1 &&
  ./obj_dir/sa_sim >> sim.log 2>&1 &&
  ! grep -q "Test failed" sim.log &&
  echo "Simulation passed, see sim.log" ||
  { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/sa_patterns.hex ====
// One beat per line: tlast nibble, then lanes 0 to 3 as 8 hex digits each, lane 3 lowest
// Each job is weight rows W[0] to W[3] followed by four input rows
000000001000000020000000300000004
000000005000000060000000700000008
0000000090000000a0000000b0000000c
00000000d0000000e0000000f00000010
000000001000000000000000000000000
000000000000000010000000000000000
000000001000000010000000100000001
100000002000000030000000400000005
0ffffffff000000028000000000000003
012345678ffffffff000000017fffffff
000000010000000200000003000000040
0deadbeef00000000cafef00d00000001
00000000300000005000000070000000b
0ffffffff000000010000000000000002
010000000000000000000000100000000
100000001000000020000000300000004
